// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // ----------------------------------------
    // Major opcodes handled by the lanes.
    // ----------------------------------------
    localparam logic [6:0] OPC_R      = 7'b0110011; // Register-register ALU.
    localparam logic [6:0] OPC_I      = 7'b0010011; // Register-immediate ALU.
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // Loads, address only.
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // Stores, address only.
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // Branch compare.

    // ALU control codes, as driven by the ALU decoder.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SLL  = 4'b0101,
        ALU_SLT  = 4'b0110,
        ALU_SLTU = 4'b0111,
        ALU_SRL  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_ctrl_t;

    // Main decoder to ALU decoder. Bit 1 selects funct3 decode.
    typedef enum logic [1:0] {
        ALU_OP_MEM    = 2'b00, // Address add.
        ALU_OP_BRANCH = 2'b01, // Compare by subtract.
        ALU_OP_FUNCT  = 2'b10  // Decode by funct3.
    } alu_op_t;

    // Immediate form to extend.
    typedef enum logic [1:0] {
        IMM_NONE = 2'b00,
        IMM_I    = 2'b01,
        IMM_S    = 2'b10
    } imm_sel_t;

    // ----------------------------------------
    // Instruction word views.
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7; // Also I immediate [11:5].
        logic [4:0] rs2;    // Also I immediate [4:0].
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi; // S immediate [11:5].
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // S immediate [4:0].
        logic [6:0] opcode;
    } rv_s_fmt_t;

    // One word, two decodes.
    typedef union packed {
        rv_r_fmt_t r;
        rv_s_fmt_t s;
    } rv_instr_u;

endpackage

// ==== design/exec_pkg.sv ====
package exec_pkg;

    import rv_isa_pkg::*;

    // ----------------------------------------
    // Cluster transport.
    // ----------------------------------------
    localparam int TAG_W = 4; // Request tag width.

    // One request, 100 bits.
    typedef struct packed {
        logic [TAG_W-1:0] tag;     // Returned with the result.
        rv_instr_u        instr;   // Instruction word.
        logic [31:0]      rs1_val; // Source operand 1.
        logic [31:0]      rs2_val; // Source operand 2.
    } exec_req_t;

    // One response, 38 bits.
    typedef struct packed {
        logic [TAG_W-1:0] tag;     // Copied from the request.
        logic [31:0]      result;  // ALU result, zero when illegal.
        logic             zero;    // Result equals zero.
        logic             illegal; // Opcode not supported.
    } exec_rsp_t;

endpackage

// ==== design/alu_decoder.sv ====
`timescale 1ns/10ps

module alu_decoder
    import rv_isa_pkg::*;
(
    // Clock, used by the check only.
    input  logic       i_clk,

    // Decode inputs.
    input  alu_op_t    i_alu_op,
    input  logic [2:0] i_func_3,
    input  logic       i_func_7_5,
    input  logic       i_op_5,

    // Control output.
    output alu_ctrl_t  o_alu_control
);

    logic s_op_func_7; // Alternate function select.

    // Only R-type has opcode bit 5 set, so I-type never picks SUB or SRA.
    assign s_op_func_7 = i_op_5 & i_func_7_5;

    // ----------------------------------------
    // Control code select.
    // ----------------------------------------
    always_comb begin
        case (i_alu_op)
            ALU_OP_FUNCT: begin
                case (i_func_3)
                    3'b000:  o_alu_control = s_op_func_7 ? ALU_SUB : ALU_ADD;
                    3'b001:  o_alu_control = ALU_SLL;
                    3'b010:  o_alu_control = ALU_SLT;
                    3'b011:  o_alu_control = ALU_SLTU;
                    3'b100:  o_alu_control = ALU_XOR;
                    3'b101:  o_alu_control = s_op_func_7 ? ALU_SRA : ALU_SRL;
                    3'b110:  o_alu_control = ALU_OR;
                    default: o_alu_control = ALU_AND; // funct3 111.
                endcase
            end
            ALU_OP_BRANCH: o_alu_control = ALU_SUB; // Compare rs1 with rs2.
            default:       o_alu_control = ALU_ADD; // Load/store address.
        endcase
    end

    // Code must stay within the ten the ALU implements.
    property p_ctrl_in_range;
        @(posedge i_clk) !$isunknown(o_alu_control) |-> (o_alu_control <= ALU_SRA);
    endproperty

    a_ctrl_in_range: assert property (p_ctrl_in_range)
        else $error("alu_decoder: unused control code %b", o_alu_control);

endmodule

// ==== design/main_decoder.sv ====
`timescale 1ns/10ps

module main_decoder
    import rv_isa_pkg::*;
(
    // Opcode field.
    input  logic [6:0] i_opcode,

    // Decode outputs.
    output alu_op_t    o_alu_op,
    output imm_sel_t   o_imm_sel,
    output logic       o_use_imm,
    output logic       o_illegal
);

    // ----------------------------------------
    // Opcode class decode.
    // ----------------------------------------
    always_comb begin
        // Defaults match an unsupported opcode.
        o_alu_op  = ALU_OP_MEM;
        o_imm_sel = IMM_NONE;
        o_use_imm = 1'b0;
        o_illegal = 1'b0;

        case (i_opcode)
            OPC_R: begin
                o_alu_op  = ALU_OP_FUNCT; // B from rs2.
            end
            OPC_I: begin
                o_alu_op  = ALU_OP_FUNCT;
                o_imm_sel = IMM_I;
                o_use_imm = 1'b1;         // B from immediate.
            end
            OPC_LOAD: begin
                o_alu_op  = ALU_OP_MEM;   // rs1 + offset.
                o_imm_sel = IMM_I;
                o_use_imm = 1'b1;
            end
            OPC_STORE: begin
                o_alu_op  = ALU_OP_MEM;
                o_imm_sel = IMM_S;        // Split offset.
                o_use_imm = 1'b1;
            end
            OPC_BRANCH: begin
                o_alu_op  = ALU_OP_BRANCH; // rs1 - rs2.
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu
    import rv_isa_pkg::*;
(
    // Operands and function.
    input  logic [31:0] i_a,
    input  logic [31:0] i_b,
    input  alu_ctrl_t   i_ctrl,

    // Result.
    output logic [31:0] o_result,
    output logic        o_zero
);

    logic [4:0] s_shamt; // Shift amount.

    assign s_shamt = i_b[4:0]; // Upper bits of B ignored for shifts.

    // ----------------------------------------
    // Function select.
    // ----------------------------------------
    always_comb begin
        case (i_ctrl)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLL:  o_result = i_a << s_shamt;
            ALU_SLT:  o_result = {31'b0, $signed(i_a) < $signed(i_b)}; // Signed.
            ALU_SLTU: o_result = {31'b0, i_a < i_b};                   // Unsigned.
            ALU_SRL:  o_result = i_a >> s_shamt;
            ALU_SRA:  o_result = $unsigned($signed(i_a) >>> s_shamt);  // Sign fill.
            default:  o_result = 32'b0;
        endcase
    end

    // Branch equality comes from the SUB result.
    assign o_zero = (o_result == 32'b0);

endmodule

// ==== design/exec_lane.sv ====
`timescale 1ns/10ps

module exec_lane
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_arst_n,

    // Request side.
    input  logic      i_req_valid,
    input  exec_req_t i_req,
    output logic      o_req_ready,

    // Response side.
    output logic      o_rsp_valid,
    output exec_rsp_t o_rsp,
    input  logic      i_rsp_ready
);

    rv_instr_u   s_instr;            // Instruction view.
    alu_op_t     s_alu_op;
    imm_sel_t    s_imm_sel;
    logic        s_use_imm;
    logic        s_illegal;
    alu_ctrl_t   s_alu_ctrl;
    logic [31:0] s_imm_i, s_imm_s;   // Extended immediates.
    logic [31:0] s_imm, s_opnd_b;
    logic [31:0] s_result;
    logic        s_zero;
    logic        s_accept;           // Request taken this edge.

    assign s_instr = i_req.instr;

    // ----------------------------------------
    // Immediates and operand B.
    // ----------------------------------------
    assign s_imm_i = {{20{s_instr.r.funct7[6]}}, s_instr.r.funct7, s_instr.r.rs2};
    assign s_imm_s = {{20{s_instr.s.imm_hi[6]}}, s_instr.s.imm_hi, s_instr.s.imm_lo};

    assign s_imm    = (s_imm_sel == IMM_I) ? s_imm_i :
                      (s_imm_sel == IMM_S) ? s_imm_s : 32'b0;
    assign s_opnd_b = s_use_imm ? s_imm : i_req.rs2_val;

    main_decoder u_main_decoder (
        .i_opcode  ( s_instr.r.opcode ),
        .o_alu_op  ( s_alu_op         ),
        .o_imm_sel ( s_imm_sel        ),
        .o_use_imm ( s_use_imm        ),
        .o_illegal ( s_illegal        )
    );

    alu_decoder u_alu_decoder (
        .i_clk         ( i_clk                 ),
        .i_alu_op      ( s_alu_op              ),
        .i_func_3      ( s_instr.r.funct3      ),
        .i_func_7_5    ( s_instr.r.funct7[5]   ),
        .i_op_5        ( s_instr.r.opcode[5]   ),
        .o_alu_control ( s_alu_ctrl            )
    );

    alu u_alu (
        .i_a      ( i_req.rs1_val ),
        .i_b      ( s_opnd_b      ),
        .i_ctrl   ( s_alu_ctrl    ),
        .o_result ( s_result      ),
        .o_zero   ( s_zero        )
    );

    // ----------------------------------------
    // One-entry output register.
    // ----------------------------------------
    assign o_req_ready = !o_rsp_valid || i_rsp_ready; // Empty or draining.
    assign s_accept    = i_req_valid && o_req_ready;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)        o_rsp_valid <= 1'b0;
        else if (s_accept)    o_rsp_valid <= 1'b1;
        else if (i_rsp_ready) o_rsp_valid <= 1'b0; // Drained.
    end

    always_ff @(posedge i_clk) begin
        if (s_accept) begin
            o_rsp.tag     <= i_req.tag;
            o_rsp.result  <= s_illegal ? 32'b0 : s_result; // Forced clear.
            o_rsp.zero    <= s_illegal ? 1'b0  : s_zero;
            o_rsp.illegal <= s_illegal;
        end
    end

    // Held response must not change until taken.
    a_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
        else $error("exec_lane: response changed while stalled");

endmodule

// ==== design/lane_dispatch.sv ====
`timescale 1ns/10ps

module lane_dispatch
    import exec_pkg::*;
#(
    parameter int N_LANES = 4
) (
    input  logic               i_clk,
    input  logic               i_arst_n,

    // Incoming requests.
    input  logic               i_req_valid,
    input  exec_req_t          i_req,
    output logic               o_req_ready,

    // Per-lane requests.
    output logic [N_LANES-1:0] o_lane_valid,
    output exec_req_t          o_lane_req [N_LANES],
    input  logic [N_LANES-1:0] i_lane_ready
);

    localparam int PTR_W = $clog2(N_LANES);

    logic [PTR_W-1:0] s_ptr; // Lane that takes the next request.

    // Payload fans out, only the pointed lane sees valid.
    always_comb begin
        o_lane_valid        = '0;
        o_lane_valid[s_ptr] = i_req_valid;
        for (int i = 0; i < N_LANES; i++) o_lane_req[i] = i_req;
    end

    assign o_req_ready = i_lane_ready[s_ptr];

    // Advance with wrap on each transfer.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s_ptr <= '0;
        end else if (i_req_valid && o_req_ready) begin
            s_ptr <= (s_ptr == PTR_W'(N_LANES - 1)) ? '0 : s_ptr + 1'b1;
        end
    end

    a_one_lane: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0(o_lane_valid))
        else $error("lane_dispatch: more than one lane valid");

endmodule

// ==== design/lane_collect.sv ====
`timescale 1ns/10ps

module lane_collect
    import exec_pkg::*;
#(
    parameter int N_LANES = 4
) (
    input  logic               i_clk,
    input  logic               i_arst_n,

    // Per-lane responses.
    input  logic [N_LANES-1:0] i_lane_valid,
    input  exec_rsp_t          i_lane_rsp [N_LANES],
    output logic [N_LANES-1:0] o_lane_ready,

    // Outgoing responses.
    output logic               o_rsp_valid,
    output exec_rsp_t          o_rsp,
    input  logic               i_rsp_ready
);

    localparam int PTR_W = $clog2(N_LANES);

    logic [PTR_W-1:0] s_ptr; // Lane drained next, tracks dispatch order.

    // ----------------------------------------
    // Output mux and ready steering.
    // ----------------------------------------
    assign o_rsp_valid = i_lane_valid[s_ptr];
    assign o_rsp       = i_lane_rsp[s_ptr];

    always_comb begin
        o_lane_ready        = '0;
        o_lane_ready[s_ptr] = i_rsp_ready; // Other lanes hold.
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s_ptr <= '0;
        end else if (o_rsp_valid && i_rsp_ready) begin
            s_ptr <= (s_ptr == PTR_W'(N_LANES - 1)) ? '0 : s_ptr + 1'b1;
        end
    end

endmodule

// ==== design/exec_cluster.sv ====
`timescale 1ns/10ps

module exec_cluster
    import exec_pkg::*;
#(
    parameter int N_LANES = 4
) (
    input  logic      i_clk,
    input  logic      i_arst_n,

    input  logic      i_req_valid,
    input  exec_req_t i_req,
    output logic      o_req_ready,

    output logic      o_rsp_valid,
    output exec_rsp_t o_rsp,
    input  logic      i_rsp_ready
);

    logic [N_LANES-1:0] s_req_valid, s_req_ready; // Dispatch to lanes.
    exec_req_t          s_req [N_LANES];
    logic [N_LANES-1:0] s_rsp_valid, s_rsp_ready; // Lanes to collect.
    exec_rsp_t          s_rsp [N_LANES];

    lane_dispatch #(.N_LANES(N_LANES)) u_dispatch (
        .i_clk        ( i_clk       ),
        .i_arst_n     ( i_arst_n    ),
        .i_req_valid  ( i_req_valid ),
        .i_req        ( i_req       ),
        .o_req_ready  ( o_req_ready ),
        .o_lane_valid ( s_req_valid ),
        .o_lane_req   ( s_req       ),
        .i_lane_ready ( s_req_ready )
    );

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        exec_lane u_lane (
            .i_clk       ( i_clk          ),
            .i_arst_n    ( i_arst_n       ),
            .i_req_valid ( s_req_valid[i] ),
            .i_req       ( s_req[i]       ),
            .o_req_ready ( s_req_ready[i] ),
            .o_rsp_valid ( s_rsp_valid[i] ),
            .o_rsp       ( s_rsp[i]       ),
            .i_rsp_ready ( s_rsp_ready[i] )
        );
    end

    lane_collect #(.N_LANES(N_LANES)) u_collect (
        .i_clk        ( i_clk       ),
        .i_arst_n     ( i_arst_n    ),
        .i_lane_valid ( s_rsp_valid ),
        .i_lane_rsp   ( s_rsp       ),
        .o_lane_ready ( s_rsp_ready ),
        .o_rsp_valid  ( o_rsp_valid ),
        .o_rsp        ( o_rsp       ),
        .i_rsp_ready  ( i_rsp_ready )
    );

endmodule

// ==== dv/tb_exec_cluster.sv ====
`timescale 1ns/10ps

module tb_exec_cluster
    import rv_isa_pkg::*, exec_pkg::*;
();

    localparam int TIMEOUT = 2000; // Cycles allowed per wait.

    logic      i_clk = 1'b0;
    logic      i_arst_n, i_req_valid, i_rsp_ready;
    exec_req_t i_req;
    logic      o_req_ready, o_rsp_valid;
    exec_rsp_t o_rsp;

    exec_rsp_t exp_q [$];          // Expected responses, acceptance order.
    exec_rsp_t exp_head;           // Head of exp_q, sampled by the checks.
    logic      exp_avail = 1'b0;
    logic      rsp_xfer;
    int        n_acc = 0, n_rsp = 0, errors = 0, n_tests = 0;
    logic [TAG_W-1:0] next_tag = '0;

    exec_cluster #(.N_LANES(4)) u_dut (.*);

    always #50 i_clk = ~i_clk; // 100 ns period.

    // ----------------------------------------
    // Reference model from the ISA encoding.
    // ----------------------------------------
    function automatic exec_rsp_t model_rsp(input exec_req_t rq);
        logic [31:0] w, a, b, r;
        logic        alt;
        exec_rsp_t   e;
        w = rq.instr;
        a = rq.rs1_val;
        r = '0;
        e.tag = rq.tag;
        e.illegal = 1'b0;
        case (w[6:0])
            OPC_R, OPC_I: begin
                b   = (w[6:0] == OPC_R) ? rq.rs2_val : {{20{w[31]}}, w[31:20]};
                alt = (w[6:0] == OPC_R) && w[30]; // Immediate forms never pick SUB/SRA.
                case (w[14:12])
                    3'd0: r = alt ? a - b : a + b;
                    3'd1: r = a << b[4:0];
                    3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3: r = (a < b) ? 32'd1 : 32'd0;
                    3'd4: r = a ^ b;
                    3'd5: begin
                        if (alt) r = $signed(a) >>> b[4:0];
                        else     r = a >> b[4:0];
                    end
                    3'd6: r = a | b;
                    default: r = a & b;
                endcase
            end
            OPC_LOAD:   r = a + {{20{w[31]}}, w[31:20]};            // I offset.
            OPC_STORE:  r = a + {{20{w[31]}}, w[31:25], w[11:7]};   // S offset.
            OPC_BRANCH: r = a - rq.rs2_val;
            default:    e.illegal = 1'b1;
        endcase
        e.result = r;
        e.zero   = !e.illegal && (r == 32'b0);
        return e;
    endfunction

    // Random fields, then the ones under test.
    function automatic exec_req_t make_req(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic f7_5);
        exec_req_t rq;
        rq.tag   = '0;
        rq.instr = $urandom;
        rq.instr.r.opcode = opc;
        rq.instr.r.funct3 = f3;
        if (opc == OPC_R) rq.instr.r.funct7 = {1'b0, f7_5, 5'b0};
        else rq.instr.r.funct7[5] = f7_5;
        rq.rs1_val = $urandom;
        rq.rs2_val = ($urandom % 4 == 0) ? rq.rs1_val : $urandom; // Hits the zero flag.
        return rq;
    endfunction

    function automatic logic [6:0] pick_illegal();
        logic [6:0] opcs [6] = '{7'b0110111, 7'b0010111, 7'b1101111,
                                 7'b1100111, 7'b0001111, 7'b1110011};
        return opcs[$urandom % 6];
    endfunction

    // ----------------------------------------
    // Scoreboard.
    // ----------------------------------------
    always @(posedge i_clk) begin
        if (o_rsp_valid && i_rsp_ready) begin
            n_rsp++;
            if (exp_q.size() > 0) void'(exp_q.pop_front());
        end
        if (i_req_valid && o_req_ready) begin
            exp_q.push_back(model_rsp(i_req));
            n_acc++;
        end
        exp_avail = (exp_q.size() > 0);
        if (exp_avail) exp_head = exp_q[0];
    end

    assign rsp_xfer = o_rsp_valid && i_rsp_ready;

    // Counts one failed check and reports it.
    task automatic count_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    a_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (n_acc == 0) |-> !o_rsp_valid)
        else count_error($sformatf("FAIL %0t o_rsp_valid exp=0 got=1", $time));
    a_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rsp_xfer |-> exp_avail)
        else count_error($sformatf("ERROR %0t: response with no request outstanding", $time));
    a_tag: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rsp_xfer && exp_avail |-> o_rsp.tag == exp_head.tag)
        else count_error($sformatf("FAIL %0t o_rsp.tag exp=%h got=%h", $time,
            $sampled(exp_head.tag), $sampled(o_rsp.tag)));
    a_result: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rsp_xfer && exp_avail |-> o_rsp.result == exp_head.result)
        else count_error($sformatf("FAIL %0t o_rsp.result exp=%h got=%h", $time,
            $sampled(exp_head.result), $sampled(o_rsp.result)));
    a_zero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rsp_xfer && exp_avail |-> o_rsp.zero == exp_head.zero)
        else count_error($sformatf("FAIL %0t o_rsp.zero exp=%b got=%b", $time,
            $sampled(exp_head.zero), $sampled(o_rsp.zero)));
    a_illegal: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rsp_xfer && exp_avail |-> o_rsp.illegal == exp_head.illegal)
        else count_error($sformatf("FAIL %0t o_rsp.illegal exp=%b got=%b", $time,
            $sampled(exp_head.illegal), $sampled(o_rsp.illegal)));

    // ----------------------------------------
    // Stimulus tasks.
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("ERROR %0t: %s", $time, why);
        $display("=== FAIL ===");
        $finish;
    endtask

    // Falling edge, with fresh random back-pressure.
    task automatic next_fall();
        @(negedge i_clk);
        i_rsp_ready = ($urandom % 4) != 0;
    endtask

    task automatic send_req(input exec_req_t rq);
        int start, waited;
        start = n_acc;
        waited = 0;
        rq.tag = next_tag;
        next_tag++;
        i_req = rq;
        i_req_valid = 1'b1;
        while (n_acc == start) begin // Held stable until accepted.
            next_fall();
            waited++;
            if (waited > TIMEOUT) abort_run("request never accepted");
        end
        i_req_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            next_fall();
            waited++;
            if (waited > TIMEOUT) abort_run("responses did not drain");
        end
    endtask

    task automatic end_test(input string name, inout int mark);
        drain();
        n_tests++;
        $display("test %s done, %0d errors", name, errors - mark);
        mark = errors;
    endtask

    initial begin
        int        mark;
        exec_req_t rq;
        mark = 0;
        void'($urandom(59192));
        i_arst_n = 1'b0;
        i_req_valid = 1'b0;
        i_req = '0;
        i_rsp_ready = 1'b0;
        repeat (16) @(negedge i_clk);
        i_arst_n = 1'b1;
        for (int i = 0; i < 8; i++) next_fall(); // Idle, no request yet.
        end_test("reset", mark);

        for (int i = 0; i < 64; i++) send_req(make_req(OPC_R, i[2:0], i[3]));
        end_test("r_type", mark);
        for (int i = 0; i < 64; i++) send_req(make_req(OPC_I, i[2:0], i[3]));
        end_test("i_type", mark);
        for (int i = 0; i < 96; i++) begin
            send_req(make_req((i % 3 == 0) ? OPC_LOAD : (i % 3 == 1) ? OPC_STORE : OPC_BRANCH,
                              3'($urandom), 1'($urandom)));
        end
        end_test("mem_branch", mark);
        for (int i = 0; i < 16; i++) begin
            rq = make_req(pick_illegal(), 3'($urandom), 1'b0);
            if (i[0]) begin
                rq.rs1_val = '0; // Raw ALU result is zero, so zero must be forced low.
                rq.rs2_val = '0;
            end
            send_req(rq);
        end
        end_test("illegal", mark);

        // Mixed classes, streaming against random ready.
        for (int i = 0; i < 300; i++) begin
            case ($urandom % 6)
                0: send_req(make_req(OPC_R, 3'($urandom), 1'($urandom)));
                1: send_req(make_req(OPC_I, 3'($urandom), 1'($urandom)));
                2: send_req(make_req(OPC_LOAD, 3'($urandom), 1'($urandom)));
                3: send_req(make_req(OPC_STORE, 3'($urandom), 1'($urandom)));
                4: send_req(make_req(OPC_BRANCH, 3'($urandom), 1'($urandom)));
                default: send_req(make_req(pick_illegal(), 3'($urandom), 1'b0));
            endcase
        end
        drain();
        for (int i = 0; i < 8; i++) next_fall(); // A duplicate would show here.
        if (n_rsp != n_acc) begin
            errors++;
            $display("ERROR %0t: %0d responses for %0d requests", $time, n_rsp, n_acc);
        end
        end_test("random_bp", mark);

        $display("tests %0d, requests %0d, responses %0d, errors %0d",
                 n_tests, n_acc, n_rsp, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
design/rv_isa_pkg.sv
design/exec_pkg.sv
design/alu_decoder.sv
design/main_decoder.sv
design/alu.sv
design/exec_lane.sv
design/lane_dispatch.sv
design/lane_collect.sv
design/exec_cluster.sv
dv/tb_exec_cluster.sv
